/* Makefile */
VERILATOR  ?= verilator
TOP        ?= icache_tb
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/cache_data_ram.sv */
`timescale 1ns/1ns

module cache_data_ram (
    input  logic                           clk,
    input  logic                           en,
    input  logic                           we,
    input  logic [cache_pkg::INDEX_W-1:0]  addr,
    input  logic [2*cache_pkg::LINE_W-1:0] bit_we,
    input  logic [2*cache_pkg::LINE_W-1:0] wdata,
    output logic [2*cache_pkg::LINE_W-1:0] rdata
);
    import cache_pkg::*;

    // way 1 in the upper half, way 0 in the lower half
    logic [2*LINE_W-1:0] mem [SETS];

    // rdata keeps the last read while idle or writing
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= (mem[addr] & ~bit_we) | (wdata & bit_we);
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* hdl/cache_pkg.sv */
package cache_pkg;

    // address split into tag, index and byte offset
    localparam int ADDR_W   = 32;
    localparam int TAG_W    = 23;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;

    localparam int SETS = 64;

    // a line holds two instruction words
    localparam int WORD_W = 32;
    localparam int LINE_W = 64;

    // lookup is entered one cycle after a request is taken
    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        replace,
        refill
    } cache_state_t;

endpackage

/* hdl/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         run,
    input  logic                         redirect,
    input  logic [cache_pkg::ADDR_W-1:0] redirect_pc,
    output logic                         req_valid,
    output logic [cache_pkg::ADDR_W-1:0] req_addr,
    input  logic                         addr_ok,
    input  logic                         data_ok,
    input  logic [cache_pkg::WORD_W-1:0] rdata,
    output logic                         insn_valid,
    output logic [cache_pkg::ADDR_W-1:0] insn_pc,
    output logic [cache_pkg::WORD_W-1:0] insn_data,
    input  logic                         insn_ready
);
    import cache_pkg::*;

    logic [ADDR_W-1:0] next_pc;
    logic              accept;
    logic              raise;
    logic              pop;
    // raised and not yet answered, the held request included
    logic [1:0]        pending;

    // pcs of accepted requests, answered in order
    logic [ADDR_W-1:0] pc_q [2];
    logic              pc_wp;
    logic              pc_rp;

    // 2-entry output fifo
    logic [ADDR_W-1:0] out_pc [2];
    logic [WORD_W-1:0] out_data [2];
    logic              out_wp;
    logic              out_rp;
    logic [1:0]        out_cnt;

    assign accept = req_valid && addr_ok;
    assign pop    = insn_valid && insn_ready;

    // every pending request owns a free fifo slot, so data_ok never finds it full
    assign raise = run && !redirect && (!req_valid || accept)
                && ((2'd2 - out_cnt) > pending);

    // a held request is not withdrawn by redirect, it completes first
    always_ff @(posedge clk) begin
        if (rst) begin
            next_pc   <= '0;
            req_valid <= 1'b0;
            pending   <= '0;
        end else begin
            if (redirect) begin
                next_pc <= redirect_pc;
            end else if (raise) begin
                next_pc <= next_pc + ADDR_W'(4);
            end
            if (raise) begin
                req_valid <= 1'b1;
            end else if (accept) begin
                req_valid <= 1'b0;
            end
            pending <= pending + {1'b0, raise} - {1'b0, data_ok};
        end
    end

    always_ff @(posedge clk) begin
        if (raise) begin
            req_addr <= next_pc;
        end
        if (accept) begin
            pc_q[pc_wp] <= req_addr;
        end
        if (data_ok) begin
            out_pc[out_wp]   <= pc_q[pc_rp];
            out_data[out_wp] <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_wp   <= 1'b0;
            pc_rp   <= 1'b0;
            out_wp  <= 1'b0;
            out_rp  <= 1'b0;
            out_cnt <= '0;
        end else begin
            if (accept) begin
                pc_wp <= ~pc_wp;
            end
            if (data_ok) begin
                pc_rp  <= ~pc_rp;
                out_wp <= ~out_wp;
            end
            if (pop) begin
                out_rp <= ~out_rp;
            end
            out_cnt <= out_cnt + {1'b0, data_ok} - {1'b0, pop};
        end
    end

    assign insn_valid = (out_cnt != 2'd0);
    assign insn_pc    = out_pc[out_rp];
    assign insn_data  = out_data[out_rp];

endmodule

/* hdl/icache.sv */
`timescale 1ns/1ns

module icache (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    input  logic [cache_pkg::ADDR_W-1:0] req_addr,
    output logic                         addr_ok,
    output logic                         data_ok,
    output logic [cache_pkg::WORD_W-1:0] rdata,
    output logic                         rd_req,
    output logic [cache_pkg::ADDR_W-1:0] rd_addr,
    input  logic                         ret_valid,
    input  logic [cache_pkg::LINE_W-1:0] ret_data
);
    import cache_pkg::*;

    cache_state_t state;
    cache_state_t next_state;

    logic               accept;
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;

    // request buffer
    logic [TAG_W-1:0]   reg_tag;
    logic [INDEX_W-1:0] reg_index;
    logic               reg_word;

    logic [TAG_W-1:0] tag_way0 [SETS];
    logic [TAG_W-1:0] tag_way1 [SETS];
    logic [SETS-1:0]  valid_way0;
    logic [SETS-1:0]  valid_way1;
    logic             way0_hit;
    logic             way1_hit;
    logic             cache_hit;

    logic              replace_way;
    logic [LINE_W-1:0] miss_line;

    logic                ram_en;
    logic                ram_we;
    logic [INDEX_W-1:0]  ram_addr;
    logic [2*LINE_W-1:0] ram_bit_we;
    logic [2*LINE_W-1:0] ram_wdata;
    logic [2*LINE_W-1:0] ram_rdata;
    logic [LINE_W-1:0]   hit_line;
    logic [LINE_W-1:0]   out_line;

    assign req_tag   = req_addr[ADDR_W-1 -: TAG_W];
    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign accept    = req_valid && addr_ok;

    always_ff @(posedge clk) begin
        if (accept) begin
            reg_tag   <= req_tag;
            reg_index <= req_index;
            reg_word  <= req_addr[OFFSET_W-1];
        end
    end

    // tag table, looked up with the buffered index
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_way0 <= '0;
            valid_way1 <= '0;
        end else if (state == replace) begin
            if (replace_way) begin
                valid_way1[reg_index] <= 1'b1;
            end else begin
                valid_way0[reg_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == replace) begin
            if (replace_way) begin
                tag_way1[reg_index] <= reg_tag;
            end else begin
                tag_way0[reg_index] <= reg_tag;
            end
        end
    end

    assign way0_hit  = valid_way0[reg_index] && (tag_way0[reg_index] == reg_tag);
    assign way1_hit  = valid_way1[reg_index] && (tag_way1[reg_index] == reg_tag);
    assign cache_hit = way0_hit || way1_hit;

    // round-robin victim, flips after each fill
    always_ff @(posedge clk) begin
        if (rst) begin
            replace_way <= 1'b0;
        end else if (state == replace) begin
            replace_way <= ~replace_way;
        end
    end

    // miss buffer
    always_ff @(posedge clk) begin
        if (state == miss && ret_valid) begin
            miss_line <= ret_data;
        end
    end

    // read on accept, write the victim way in replace
    assign ram_we     = (state == replace);
    assign ram_en     = accept || ram_we;
    assign ram_addr   = ram_we ? reg_index : req_index;
    assign ram_wdata  = {miss_line, miss_line};
    assign ram_bit_we = replace_way ? {{LINE_W{1'b1}}, {LINE_W{1'b0}}}
                                    : {{LINE_W{1'b0}}, {LINE_W{1'b1}}};

    cache_data_ram i_cache_data_ram (
        .clk    (clk),
        .en     (ram_en),
        .we     (ram_we),
        .addr   (ram_addr),
        .bit_we (ram_bit_we),
        .wdata  (ram_wdata),
        .rdata  (ram_rdata)
    );

    assign hit_line = way1_hit ? ram_rdata[LINE_W +: LINE_W] : ram_rdata[0 +: LINE_W];
    assign out_line = (state == refill) ? miss_line : hit_line;
    assign rdata    = reg_word ? out_line[WORD_W +: WORD_W] : out_line[0 +: WORD_W];

    assign addr_ok = (state == idle) || (state == lookup && cache_hit);
    assign data_ok = (state == lookup && cache_hit) || (state == refill);
    assign rd_req  = (state == miss);
    assign rd_addr = {reg_tag, reg_index, {OFFSET_W{1'b0}}};

    always_comb begin
        case (state)
            idle:    next_state = req_valid ? lookup : idle;
            lookup: begin
                if (!cache_hit) begin
                    next_state = miss;
                end else if (req_valid) begin
                    next_state = lookup;
                end else begin
                    next_state = idle;
                end
            end
            miss:    next_state = ret_valid ? replace : miss;
            replace: next_state = refill;
            refill:  next_state = idle;
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/1ns

module icache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          run,
    input  logic                          redirect,
    input  logic [cache_pkg::ADDR_W-1:0]  redirect_pc,
    output logic                          insn_valid,
    output logic [cache_pkg::ADDR_W-1:0]  insn_pc,
    output logic [cache_pkg::WORD_W-1:0]  insn_data,
    input  logic                          insn_ready,
    input  logic                          imem_we,
    input  logic [mem_pkg::MEM_LINE_AW:0] imem_addr,
    input  logic [cache_pkg::WORD_W-1:0]  imem_wdata
);
    import cache_pkg::*;

    // fetch to cache
    logic              req_valid;
    logic [ADDR_W-1:0] req_addr;
    logic              addr_ok;
    logic              data_ok;
    logic [WORD_W-1:0] rdata;

    // cache to memory
    logic              rd_req;
    logic [ADDR_W-1:0] rd_addr;
    logic              ret_valid;
    logic [LINE_W-1:0] ret_data;

    fetch_unit i_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .insn_valid  (insn_valid),
        .insn_pc     (insn_pc),
        .insn_data   (insn_data),
        .insn_ready  (insn_ready)
    );

    icache i_icache (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    mem_ctrl i_mem_ctrl (
        .clk        (clk),
        .rst        (rst),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data)
    );

endmodule

/* hdl/mem_ctrl.sv */
`timescale 1ns/1ns

module mem_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rd_req,
    input  logic [cache_pkg::ADDR_W-1:0]  rd_addr,
    input  logic                          imem_we,
    input  logic [mem_pkg::MEM_LINE_AW:0] imem_addr,
    input  logic [cache_pkg::WORD_W-1:0]  imem_wdata,
    output logic                          ret_valid,
    output logic [cache_pkg::LINE_W-1:0]  ret_data
);
    import cache_pkg::*;
    import mem_pkg::*;

    logic [LINE_W-1:0]      store [MEM_LINES];
    mem_state_t             state;
    logic [LAT_W-1:0]       lat_cnt;
    logic [MEM_LINE_AW-1:0] rd_line;

    // line number in the store, upper bits dropped
    assign rd_line = rd_addr[OFFSET_W +: MEM_LINE_AW];

    // preload, even word address goes to the low half
    always_ff @(posedge clk) begin
        if (imem_we) begin
            if (imem_addr[0]) begin
                store[imem_addr[MEM_LINE_AW:1]][WORD_W +: WORD_W] <= imem_wdata;
            end else begin
                store[imem_addr[MEM_LINE_AW:1]][0 +: WORD_W] <= imem_wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mem_idle;
            lat_cnt <= '0;
        end else begin
            case (state)
                mem_idle: begin
                    if (rd_req) begin
                        state   <= mem_wait;
                        lat_cnt <= LAT_W'(MEM_LATENCY - 2);
                    end
                end
                mem_wait: begin
                    if (lat_cnt == '0) begin
                        state <= mem_resp;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                mem_resp: state <= mem_idle;
                default:  state <= mem_idle;
            endcase
        end
    end

    // line read when the request is taken
    always_ff @(posedge clk) begin
        if (state == mem_idle && rd_req) begin
            ret_data <= store[rd_line];
        end
    end

    assign ret_valid = (state == mem_resp);

endmodule

/* hdl/mem_pkg.sv */
package mem_pkg;

    // line store depth, higher line-address bits alias
    localparam int MEM_LINES   = 256;
    localparam int MEM_LINE_AW = $clog2(MEM_LINES);

    // cycles from the accepted refill request to ret_valid
    localparam int MEM_LATENCY = 4;
    localparam int LAT_W       = $clog2(MEM_LATENCY);

    typedef enum logic [1:0] {
        mem_idle,
        mem_wait,
        mem_resp
    } mem_state_t;

endpackage

/* verification/icache_tb.sv */
`timescale 1ns/1ns

module icache_tb;
    import cache_pkg::*;
    import mem_pkg::*;

    localparam int IMAGE_WORDS  = 2 * MEM_LINES;
    localparam int WAIT_LIMIT   = 4000;
    localparam int QUIET_CYCLES = 24;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    logic                 run = 1'b0;
    logic                 redirect = 1'b0;
    logic [ADDR_W-1:0]    redirect_pc = '0;
    logic                 insn_ready = 1'b0;
    logic                 imem_we = 1'b0;
    logic [MEM_LINE_AW:0] imem_addr = '0;
    logic [WORD_W-1:0]    imem_wdata = '0;
    logic                 insn_valid;
    logic [ADDR_W-1:0]    insn_pc;
    logic [WORD_W-1:0]    insn_data;

    // copy of the words written into the line store
    logic [WORD_W-1:0] image [IMAGE_WORDS];

    logic              random_ready = 1'b0;
    int                errors = 0;
    int                failures = 0;
    logic              aborted = 1'b0;
    int                delivered = 0;
    logic [ADDR_W-1:0] exp_pc = '0;
    logic [ADDR_W-1:0] jump_pc = '0;
    int                jumps_requested = 0;
    int                jumps_taken = 0;

    icache_top i_icache_top (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .insn_valid  (insn_valid),
        .insn_pc     (insn_pc),
        .insn_data   (insn_data),
        .insn_ready  (insn_ready),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata)
    );

    always #2 clk = ~clk;

    // line address bits above the store depth alias onto it
    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] pc);
        int unsigned line;
        int unsigned slot;
        line = (pc >> OFFSET_W) % MEM_LINES;
        slot = 2 * line + int'(pc[2]);
        return image[slot];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    // consumer is always ready unless the random pattern is on
    always @(posedge clk) begin
        #1;
        if (random_ready) begin
            insn_ready = ($urandom % 3) != 0;
        end else begin
            insn_ready = 1'b1;
        end
    end

    // every transfer against the expected pc stream
    always @(negedge clk) begin
        if (!rst && insn_valid && insn_ready) begin
            if (jumps_taken != jumps_requested && insn_pc == jump_pc) begin
                jumps_taken = jumps_requested;
                exp_pc = jump_pc;
            end else begin
                check_value("insn_pc", insn_pc, exp_pc);
            end
            check_value("insn_data", insn_data, expected_word(exp_pc));
            exp_pc = exp_pc + 32'd4;
            delivered++;
        end
    end

    task automatic redirect_to(input logic [ADDR_W-1:0] pc);
        if (aborted) return;
        jump_pc = pc;
        jumps_requested++;
        redirect = 1'b1;
        redirect_pc = pc;
        next_cycle();
        redirect = 1'b0;
    endtask

    task automatic wait_delivered(input int target);
        int cycles;
        if (aborted) return;
        cycles = 0;
        while (delivered < target && !aborted) begin
            next_cycle();
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout at %0t ns: only %0d of %0d instructions arrived",
                         $time, delivered, target);
                failures++;
                aborted = 1'b1;
            end
        end
    endtask

    // stop issuing and let every accepted request come back
    task automatic drain;
        int quiet;
        int cycles;
        if (aborted) return;
        run = 1'b0;
        quiet = 0;
        cycles = 0;
        while (quiet < QUIET_CYCLES && !aborted) begin
            next_cycle();
            cycles++;
            quiet = insn_valid ? 0 : quiet + 1;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout at %0t ns: fetch unit never went quiet", $time);
                failures++;
                aborted = 1'b1;
            end
        end
        if (!aborted && jumps_taken != jumps_requested) begin
            $display("redirect to %h at %0t ns was never delivered", jump_pc, $time);
            failures++;
        end
    endtask

    task automatic fetch_block(input logic [ADDR_W-1:0] start, input int count);
        int base;
        if (aborted) return;
        base = delivered;
        redirect_to(start);
        run = 1'b1;
        wait_delivered(base + count);
        drain();
    endtask

    initial begin
        void'($urandom(32'h88ae));
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // preload while fetch must stay silent
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            image[i] = $urandom;
            imem_we = 1'b1;
            imem_addr = (MEM_LINE_AW + 1)'(i);
            imem_wdata = image[i];
            if (insn_valid) begin
                $display("insn_valid high before run at %0t ns", $time);
                failures++;
            end
            next_cycle();
        end
        imem_we = 1'b0;

        // cold start from the reset address
        run = 1'b1;
        wait_delivered(40);
        drain();

        // same range again as hits
        fetch_block(32'h0000_0000, 40);

        // four tags on set 32 outnumber the two ways
        for (int round = 0; round < 3; round++) begin
            fetch_block(32'h0000_0100, 2);
            fetch_block(32'h0000_0300, 2);
            fetch_block(32'h0000_0500, 2);
            fetch_block(32'h0000_0700, 2);
        end

        // random back-pressure and a redirect while requests are in flight
        random_ready = 1'b1;
        fetch_block(32'h0000_0040, 60);
        redirect_to(32'h0000_0200);
        run = 1'b1;
        wait_delivered(delivered + 10);
        redirect_to(32'h0000_0600);
        wait_delivered(delivered + 30);
        drain();
        random_ready = 1'b0;

        // beyond the line store
        fetch_block(32'h0001_2340, 16);
        fetch_block(32'hfff0_0008, 8);

        $display("errors: %0d mismatches, %0d other failures, %0d instructions checked",
                 errors, failures, delivered);
        if (errors == 0 && failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/cache_data_ram.sv
hdl/fetch_unit.sv
hdl/icache.sv
hdl/mem_ctrl.sv
hdl/icache_top.sv
verification/icache_tb.sv
